// File: Makefile
SIM := obj_dir/Vrv_exec_core_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): rv_exec_core.f include/*.svh rtl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f rv_exec_core.f \
		--top-module rv_exec_core_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// File: include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XLEN    32
`define NREG    32
`define INST_W  64

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-hot instruction class bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define INST_UNKNOWN 0
`define INST_ADD     1
`define INST_SUB     2
`define INST_XOR     3
`define INST_OR      4
`define INST_AND     5
`define INST_SLL     6
`define INST_SRL     7
`define INST_SRA     8
`define INST_SLT     9
`define INST_SLTU    10
`define INST_ADDI    11
`define INST_XORI    12
`define INST_ORI     13
`define INST_ANDI    14
`define INST_SLLI    15
`define INST_SRLI    16
`define INST_SRAI    17
`define INST_SLTI    18
`define INST_SLTIU   19
`define INST_LB      20
`define INST_LH      21
`define INST_LW      22
`define INST_LBU     23
`define INST_LHU     24
`define INST_SB      25
`define INST_SH      26
`define INST_SW      27
`define INST_BEQ     28
`define INST_BNE     29
`define INST_BLT     30
`define INST_BGE     31
`define INST_BLTU    32
`define INST_BGEU    33
`define INST_JAL     34
`define INST_JALR    35
`define INST_LUI     36
`define INST_AUIPC   37
`define INST_ECALL   38
`define INST_EBREAK  39
`define INST_FENCE   40
`define INST_FENCEI  41
`define INST_CSRRW   42
`define INST_CSRRS   43
`define INST_CSRRC   44
`define INST_CSRRWI  45
`define INST_CSRRSI  46
`define INST_CSRRCI  47

`endif

// File: rtl/rv_commit.sv
`timescale 1ns/1ns
`default_nettype none

module rv_commit (
    input  logic             i_clk,
    input  logic             arst_n_i,
    input  logic             valid_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::word_t    result_i,
    input  rv_pkg::word_t    target_i,
    input  logic             branch_i,
    input  logic             jump_i,
    input  logic             writes_rd_i,
    input  logic             mem_i,
    input  logic             illegal_i,
    output logic             retire_o,
    output logic             wr_en_o,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::word_t    result_o,
    output logic             redirect_o,
    output rv_pkg::word_t    target_o,
    output logic             mem_o,
    output logic             illegal_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_o   <= 1'b0;
            wr_en_o    <= 1'b0;
            redirect_o <= 1'b0;
            mem_o      <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            retire_o   <= valid_i; // strobes last a single cycle.
            wr_en_o    <= valid_i & writes_rd_i & (rd_i != '0);
            redirect_o <= valid_i & (jump_i | (branch_i & result_i[0]));
            mem_o      <= valid_i & mem_i;
            illegal_o  <= valid_i & illegal_i;
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_i) begin
            rd_o     <= rd_i;
            result_o <= result_i;
            target_o <= target_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_decode (
    input  rv_pkg::word_t instr_i,
    input  rv_pkg::word_t pc_i,
    input  logic          valid_i,
    rv_exec_if.dec        dec
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    int unsigned   cls;
    rv_pkg::word_t imm_sel;
    rv_pkg::word_t imm_i_fmt;
    rv_pkg::word_t imm_s_fmt;
    rv_pkg::word_t imm_b_fmt;
    rv_pkg::word_t imm_u_fmt;
    rv_pkg::word_t imm_j_fmt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // immediate formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // class match
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cls     = `INST_UNKNOWN; // anything left unmatched is illegal.
        imm_sel = '0;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: cls = `INST_ADD;
                        3'b001: cls = `INST_SLL;
                        3'b010: cls = `INST_SLT;
                        3'b011: cls = `INST_SLTU;
                        3'b100: cls = `INST_XOR;
                        3'b101: cls = `INST_SRL;
                        3'b110: cls = `INST_OR;
                        default: cls = `INST_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) begin
                        cls = `INST_SUB;
                    end else if (funct3 == 3'b101) begin
                        cls = `INST_SRA;
                    end
                end
            end
            7'b0010011: begin
                imm_sel = imm_i_fmt;
                case (funct3)
                    3'b000: cls = `INST_ADDI;
                    3'b010: cls = `INST_SLTI;
                    3'b011: cls = `INST_SLTIU;
                    3'b100: cls = `INST_XORI;
                    3'b110: cls = `INST_ORI;
                    3'b111: cls = `INST_ANDI;
                    3'b001: begin
                        if (funct7 == 7'b0000000) begin
                            cls = `INST_SLLI;
                        end
                    end
                    default: begin
                        if (funct7 == 7'b0000000) begin
                            cls = `INST_SRLI;
                        end else if (funct7 == 7'b0100000) begin
                            cls = `INST_SRAI;
                        end
                    end
                endcase
            end
            7'b0000011: begin
                imm_sel = imm_i_fmt;
                case (funct3)
                    3'b000: cls = `INST_LB;
                    3'b001: cls = `INST_LH;
                    3'b010: cls = `INST_LW;
                    3'b100: cls = `INST_LBU;
                    3'b101: cls = `INST_LHU;
                    default: cls = `INST_UNKNOWN;
                endcase
            end
            7'b0100011: begin
                imm_sel = imm_s_fmt;
                case (funct3)
                    3'b000: cls = `INST_SB;
                    3'b001: cls = `INST_SH;
                    3'b010: cls = `INST_SW;
                    default: cls = `INST_UNKNOWN;
                endcase
            end
            7'b1100011: begin
                imm_sel = imm_b_fmt;
                case (funct3)
                    3'b000: cls = `INST_BEQ;
                    3'b001: cls = `INST_BNE;
                    3'b100: cls = `INST_BLT;
                    3'b101: cls = `INST_BGE;
                    3'b110: cls = `INST_BLTU;
                    3'b111: cls = `INST_BGEU;
                    default: cls = `INST_UNKNOWN;
                endcase
            end
            7'b1101111: begin
                imm_sel = imm_j_fmt;
                cls     = `INST_JAL;
            end
            7'b1100111: begin
                imm_sel = imm_i_fmt;
                if (funct3 == 3'b000) begin
                    cls = `INST_JALR;
                end
            end
            7'b0110111: begin
                imm_sel = imm_u_fmt;
                cls     = `INST_LUI;
            end
            7'b0010111: begin
                imm_sel = imm_u_fmt;
                cls     = `INST_AUIPC;
            end
            7'b0001111: begin
                imm_sel = imm_i_fmt;
                if (funct3 == 3'b000) begin
                    cls = `INST_FENCE;
                end else if (funct3 == 3'b001) begin
                    cls = `INST_FENCEI;
                end
            end
            7'b1110011: begin
                imm_sel = imm_i_fmt;
                case (funct3)
                    3'b000: begin
                        if (instr_i[31:7] == 25'd0) begin
                            cls = `INST_ECALL;
                        end else if (instr_i[31:7] == {12'd1, 13'd0}) begin
                            cls = `INST_EBREAK;
                        end
                    end
                    3'b001: cls = `INST_CSRRW;
                    3'b010: cls = `INST_CSRRS;
                    3'b011: cls = `INST_CSRRC;
                    3'b101: cls = `INST_CSRRWI;
                    3'b110: cls = `INST_CSRRSI;
                    3'b111: cls = `INST_CSRRCI;
                    default: cls = `INST_UNKNOWN;
                endcase
            end
            default: cls = `INST_UNKNOWN;
        endcase
    end

    assign dec.valid = valid_i;
    assign dec.inst  = rv_pkg::inst_oh_t'(1) << cls; // shifting a single one keeps it one-hot.
    assign dec.rd    = instr_i[11:7];
    assign dec.rs1   = instr_i[19:15];
    assign dec.rs2   = instr_i[24:20];
    assign dec.imm   = imm_sel;
    assign dec.pc    = pc_i;

endmodule

`default_nettype wire

// File: rtl/rv_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core (
    input  logic             i_clk,
    input  logic             arst_n_i,
    input  logic             valid_i,
    input  rv_pkg::word_t    instr_i,
    input  rv_pkg::word_t    pc_i,
    output logic             retire_o,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::word_t    result_o,
    output logic             wr_en_o,
    output logic             redirect_o,
    output rv_pkg::word_t    target_o,
    output logic             mem_o,
    output logic             illegal_o
);

    rv_pkg::word_t ex_result;
    rv_pkg::word_t ex_target;
    logic          ex_branch;
    logic          ex_jump;
    logic          ex_writes_rd;
    logic          ex_mem;
    logic          ex_illegal;

    rv_exec_if u_exec_if ();

    rv_decode u_decode (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .valid_i (valid_i),
        .dec     (u_exec_if.dec)
    );

    // the commit stage drives the write port, so the write lands as the retire cycle ends.
    rv_regfile u_regfile (
        .i_clk     (i_clk),
        .arst_n_i  (arst_n_i),
        .rf        (u_exec_if.rf),
        .wr_en_i   (wr_en_o),
        .wr_idx_i  (rd_o),
        .wr_data_i (result_o)
    );

    rv_execute u_execute (
        .ex          (u_exec_if.ex),
        .result_o    (ex_result),
        .target_o    (ex_target),
        .branch_o    (ex_branch),
        .jump_o      (ex_jump),
        .writes_rd_o (ex_writes_rd),
        .mem_o       (ex_mem),
        .illegal_o   (ex_illegal)
    );

    rv_commit u_commit (
        .i_clk       (i_clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (u_exec_if.valid),
        .rd_i        (u_exec_if.rd),
        .result_i    (ex_result),
        .target_i    (ex_target),
        .branch_i    (ex_branch),
        .jump_i      (ex_jump),
        .writes_rd_i (ex_writes_rd),
        .mem_i       (ex_mem),
        .illegal_i   (ex_illegal),
        .retire_o    (retire_o),
        .wr_en_o     (wr_en_o),
        .rd_o        (rd_o),
        .result_o    (result_o),
        .redirect_o  (redirect_o),
        .target_o    (target_o),
        .mem_o       (mem_o),
        .illegal_o   (illegal_o)
    );

endmodule

`default_nettype wire

// File: rtl/rv_exec_if.sv
`timescale 1ns/1ns
`default_nettype none

interface rv_exec_if;

    logic             valid;
    rv_pkg::inst_oh_t inst;
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    op1;  // read data of rs1.
    rv_pkg::word_t    op2;  // read data of rs2.

    modport dec (output valid, inst, rd, rs1, rs2, imm, pc);

    modport rf (input rs1, rs2, output op1, op2);

    modport ex (input valid, inst, rd, rs1, rs2, imm, pc, op1, op2);

endinterface

`default_nettype wire

// File: rtl/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_execute (
    rv_exec_if.ex         ex,
    output rv_pkg::word_t result_o,
    output rv_pkg::word_t target_o,
    output logic          branch_o,
    output logic          jump_o,
    output logic          writes_rd_o,
    output logic          mem_o,
    output logic          illegal_o
);

    rv_pkg::word_t addr;
    logic          eq;
    logic          lt_s;
    logic          lt_u;
    logic          br_take;

    assign addr = ex.op1 + ex.imm; // load, store and jalr address.
    assign eq   = (ex.op1 == ex.op2);
    assign lt_s = ($signed(ex.op1) < $signed(ex.op2));
    assign lt_u = (ex.op1 < ex.op2);

    assign br_take = (ex.inst[`INST_BEQ]  &  eq)
                   | (ex.inst[`INST_BNE]  & ~eq)
                   | (ex.inst[`INST_BLT]  &  lt_s)
                   | (ex.inst[`INST_BGE]  & ~lt_s)
                   | (ex.inst[`INST_BLTU] &  lt_u)
                   | (ex.inst[`INST_BGEU] & ~lt_u);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per class results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        result_o    = '0;
        target_o    = '0;
        branch_o    = 1'b0;
        jump_o      = 1'b0;
        writes_rd_o = 1'b1; // most classes write rd, the rest clear this below.
        mem_o       = 1'b0;
        illegal_o   = 1'b0;
        case (1'b1)
            ex.inst[`INST_ADD]:   result_o = ex.op1 + ex.op2;
            ex.inst[`INST_SUB]:   result_o = ex.op1 - ex.op2;
            ex.inst[`INST_XOR]:   result_o = ex.op1 ^ ex.op2;
            ex.inst[`INST_OR]:    result_o = ex.op1 | ex.op2;
            ex.inst[`INST_AND]:   result_o = ex.op1 & ex.op2;
            ex.inst[`INST_SLL]:   result_o = ex.op1 << ex.op2[4:0];
            ex.inst[`INST_SRL]:   result_o = ex.op1 >> ex.op2[4:0];
            ex.inst[`INST_SRA]:   result_o = $signed(ex.op1) >>> ex.op2[4:0];
            ex.inst[`INST_SLT]:   result_o = rv_pkg::word_t'(lt_s);
            ex.inst[`INST_SLTU]:  result_o = rv_pkg::word_t'(lt_u);
            ex.inst[`INST_ADDI]:  result_o = ex.op1 + ex.imm;
            ex.inst[`INST_XORI]:  result_o = ex.op1 ^ ex.imm;
            ex.inst[`INST_ORI]:   result_o = ex.op1 | ex.imm;
            ex.inst[`INST_ANDI]:  result_o = ex.op1 & ex.imm;
            ex.inst[`INST_SLLI]:  result_o = ex.op1 << ex.imm[4:0];
            ex.inst[`INST_SRLI]:  result_o = ex.op1 >> ex.imm[4:0];
            ex.inst[`INST_SRAI]:  result_o = $signed(ex.op1) >>> ex.imm[4:0];
            ex.inst[`INST_SLTI]:  result_o = rv_pkg::word_t'($signed(ex.op1) < $signed(ex.imm));
            ex.inst[`INST_SLTIU]: result_o = rv_pkg::word_t'(ex.op1 < ex.imm);
            ex.inst[`INST_LUI]:   result_o = ex.imm;
            ex.inst[`INST_AUIPC]: result_o = ex.pc + ex.imm;
            ex.inst[`INST_LB], ex.inst[`INST_LH], ex.inst[`INST_LW],
            ex.inst[`INST_LBU], ex.inst[`INST_LHU],
            ex.inst[`INST_SB], ex.inst[`INST_SH], ex.inst[`INST_SW]: begin
                result_o    = addr;
                mem_o       = 1'b1;
                writes_rd_o = 1'b0; // no load data comes back in this slice.
            end
            ex.inst[`INST_BEQ], ex.inst[`INST_BNE], ex.inst[`INST_BLT],
            ex.inst[`INST_BGE], ex.inst[`INST_BLTU], ex.inst[`INST_BGEU]: begin
                result_o    = rv_pkg::word_t'(br_take);
                target_o    = ex.pc + ex.imm;
                branch_o    = 1'b1;
                writes_rd_o = 1'b0;
            end
            ex.inst[`INST_JAL]: begin
                result_o = ex.pc + 32'd4;
                target_o = ex.pc + ex.imm;
                jump_o   = 1'b1;
            end
            ex.inst[`INST_JALR]: begin
                result_o = ex.pc + 32'd4;
                target_o = {addr[31:1], 1'b0};
                jump_o   = 1'b1;
            end
            ex.inst[`INST_ECALL], ex.inst[`INST_EBREAK], ex.inst[`INST_FENCE],
            ex.inst[`INST_FENCEI], ex.inst[`INST_CSRRW], ex.inst[`INST_CSRRS],
            ex.inst[`INST_CSRRC], ex.inst[`INST_CSRRWI], ex.inst[`INST_CSRRSI],
            ex.inst[`INST_CSRRCI]: begin
                writes_rd_o = 1'b0; // retire as no-ops.
            end
            ex.inst[`INST_UNKNOWN]: begin
                writes_rd_o = 1'b0;
                illegal_o   = 1'b1;
            end
            default: begin
                writes_rd_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t; // data, pc and immediate words.

    typedef logic [$clog2(`NREG)-1:0] reg_idx_t;

    typedef logic [`INST_W-1:0] inst_oh_t; // exactly one bit is set per instruction.

endpackage

`default_nettype wire

// File: rtl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
    input  logic             i_clk,
    input  logic             arst_n_i,
    rv_exec_if.rf            rf,
    input  logic             wr_en_i,
    input  rv_pkg::reg_idx_t wr_idx_i,
    input  rv_pkg::word_t    wr_data_i
);

    rv_pkg::word_t regs [`NREG];

    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_idx_i] <= wr_data_i; // x0 stays zero since commit never targets it.
        end
    end

    // reads see the old value on a write edge, the new one a cycle later.
    assign rf.op1 = regs[rf.rs1];
    assign rf.op2 = regs[rf.rs2];

endmodule

`default_nettype wire

// File: rv_exec_core.f
+incdir+include
rtl/rv_pkg.sv
rtl/rv_exec_if.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_commit.sv
rtl/rv_exec_core.sv
tb/rv_exec_core_chk.sv
tb/rv_exec_core_tb.sv

// File: tb/rv_exec_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core_chk (
    input logic             i_clk,
    input logic             arst_n_i,
    input logic             valid_i,
    input logic             retire_o,
    input rv_pkg::reg_idx_t rd_o,
    input logic             wr_en_o,
    input logic             redirect_o,
    input logic             mem_o,
    input logic             illegal_o
);

    a_retire_follows : assert property (@(posedge i_clk) disable iff (!arst_n_i)
        valid_i |=> retire_o) else $error("retire missing after valid input");

    a_no_retire : assert property (@(posedge i_clk) disable iff (!arst_n_i)
        !valid_i |=> !retire_o) else $error("retire without valid input");

    a_wr_nonzero : assert property (@(posedge i_clk) disable iff (!arst_n_i)
        wr_en_o |-> rd_o != '0) else $error("register write aimed at x0");

    a_illegal_quiet : assert property (@(posedge i_clk) disable iff (!arst_n_i)
        illegal_o |-> !wr_en_o && !redirect_o) else $error("illegal word had an effect");

    // strobes are cleared asynchronously, so they are low at every edge in reset.
    a_reset_low : assert property (@(posedge i_clk)
        !arst_n_i |-> !(retire_o || wr_en_o || redirect_o || mem_o || illegal_o))
        else $error("control output active during reset");

endmodule

bind rv_exec_core rv_exec_core_chk u_chk (
    .i_clk      (i_clk),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .retire_o   (retire_o),
    .rd_o       (rd_o),
    .wr_en_o    (wr_en_o),
    .redirect_o (redirect_o),
    .mem_o      (mem_o),
    .illegal_o  (illegal_o)
);

`default_nettype wire

// File: tb/rv_exec_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core_tb;

    localparam int TOTAL = 32 + 200 + 120 + 120 + 120 + 120;
    localparam int LIMIT_NS = (TOTAL + 6 * 2 + 8) * 40 + 2000;

    typedef struct packed {
        logic        valid;
        logic        wr;
        logic        redir;
        logic        mem;
        logic        ill;
        logic        has_tgt;
        logic [4:0]  rd;
        logic [31:0] res;
        logic [31:0] tgt;
    } exp_t;

    logic             i_clk;
    logic             arst_n_i;
    logic             valid_i;
    rv_pkg::word_t    instr_i;
    rv_pkg::word_t    pc_i;
    logic             retire_o;
    rv_pkg::reg_idx_t rd_o;
    rv_pkg::word_t    result_o;
    logic             wr_en_o;
    logic             redirect_o;
    rv_pkg::word_t    target_o;
    logic             mem_o;
    logic             illegal_o;

    integer      seed = 32'h8f65;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic [31:0] mregs [32];  // reference register file.
    exp_t        pend;        // instruction on the inputs.
    exp_t        chk;         // instruction retiring this cycle.
    logic        wb_en;       // write landing on the next edge.
    logic [4:0]  wb_idx;
    logic [31:0] wb_data;

    rv_exec_core i_rv_exec_core (
        .i_clk      (i_clk),
        .arst_n_i   (arst_n_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .retire_o   (retire_o),
        .rd_o       (rd_o),
        .result_o   (result_o),
        .wr_en_o    (wr_en_o),
        .redirect_o (redirect_o),
        .target_o   (target_o),
        .mem_o      (mem_o),
        .illegal_o  (illegal_o)
    );

    always #20 i_clk = ~i_clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic gen_instr(input int test, input int step, output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          k;
        r = $random(seed);
        s = $random(seed);
        f3 = s[18:16];
        case (test)
            0: w = {12'h000, step[4:0], 3'b110, 5'd0, 7'h13}; // ori x0 reads one register.
            1: begin
                if (s[20]) begin
                    w = {((f3 == 3'd0 || f3 == 3'd5) && s[19]) ? 7'h20 : 7'h00,
                         r[24:20], r[19:15], f3, r[11:7], 7'h33};
                end else begin
                    imm = r[31:20];
                    if (f3 == 3'd1) imm[11:5] = 7'h00;
                    if (f3 == 3'd5) imm[11:5] = s[19] ? 7'h20 : 7'h00;
                    w = {imm, r[19:15], f3, r[11:7], 7'h13};
                end
            end
            2: begin
                case (s[17:16])
                    2'd0: w = {r[31:12], r[11:7], 7'h37};
                    2'd1: w = {r[31:12], r[11:7], 7'h17};
                    2'd2: w = {r[31:12], r[11:7], 7'h6f};
                    default: w = {r[31:20], r[19:15], 3'b000, r[11:7], 7'h67};
                endcase
            end
            3: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                // small register range so that equal operands turn up.
                w = {r[31:25], 3'b000, r[21:20], 3'b000, r[16:15], f3, r[11:7], 7'h63};
            end
            4: begin
                k = s[15:0] % 5;
                if (s[19]) begin
                    w = {r[31:20], r[19:15], (k < 3) ? 3'(k) : 3'(k + 1), r[11:7], 7'h03};
                end else begin
                    w = {r[31:25], r[24:20], r[19:15], (k > 2) ? 3'd2 : 3'(k),
                         r[11:7], 7'h23};
                end
            end
            default: begin
                if (s[16]) begin
                    w = {r[31:7], 7'h7f};
                end else begin
                    w = {7'h00, r[24:20], r[19:15], f3, 5'd0, 7'h33}; // targets x0.
                end
            end
        endcase
    endtask

    task automatic predict(input logic [31:0] w, input logic [31:0] pc, output exp_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [31:0] ib;
        logic        cond;
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        ii = {{20{w[31]}}, w[31:20]};
        ib = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == 7'h13) b = ii;
        e = '0;
        e.valid = 1'b1;
        e.rd = w[11:7];
        case (w[6:0])
            7'h33, 7'h13: begin
                e.wr = 1'b1;
                case (w[14:12])
                    3'd0: e.res = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
                    3'd1: e.res = a << b[4:0];
                    3'd2: e.res = {31'd0, $signed(a) < $signed(b)};
                    3'd3: e.res = {31'd0, a < b};
                    3'd4: e.res = a ^ b;
                    3'd5: begin
                        if (w[30]) begin
                            e.res = $signed(a) >>> b[4:0];
                        end else begin
                            e.res = a >> b[4:0];
                        end
                    end
                    3'd6: e.res = a | b;
                    default: e.res = a & b;
                endcase
            end
            7'h03: begin
                e.mem = 1'b1;
                e.res = a + ii;
            end
            7'h23: begin
                e.mem = 1'b1;
                e.res = a + {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'h63: begin
                case (w[14:12])
                    3'd0: cond = (a == b);
                    3'd1: cond = (a != b);
                    3'd4: cond = ($signed(a) < $signed(b));
                    3'd5: cond = !($signed(a) < $signed(b));
                    3'd6: cond = (a < b);
                    default: cond = !(a < b);
                endcase
                e.res = {31'd0, cond};
                e.redir = cond;
                e.has_tgt = 1'b1;
                e.tgt = pc + ib;
            end
            7'h6f, 7'h67: begin
                e.wr = 1'b1;
                e.res = pc + 32'd4;
                e.redir = 1'b1;
                e.has_tgt = 1'b1;
                if (w[6:0] == 7'h6f) begin
                    e.tgt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end else begin
                    e.tgt = (a + ii) & 32'hffff_fffe;
                end
            end
            7'h37: begin
                e.wr = 1'b1;
                e.res = {w[31:12], 12'h000};
            end
            7'h17: begin
                e.wr = 1'b1;
                e.res = pc + {w[31:12], 12'h000};
            end
            default: e.ill = 1'b1;
        endcase
        e.wr = e.wr && (e.rd != 5'd0);
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("mismatch %s %s expected %h actual %h", name, what, exp, act);
        errors++;
    endtask

    task automatic compare_outputs(input string name, input exp_t c);
        if (retire_o !== c.valid) report_mismatch(name, "retire_o", c.valid, retire_o);
        if (wr_en_o !== c.wr) report_mismatch(name, "wr_en_o", c.wr, wr_en_o);
        if (redirect_o !== c.redir) report_mismatch(name, "redirect_o", c.redir, redirect_o);
        if (mem_o !== c.mem) report_mismatch(name, "mem_o", c.mem, mem_o);
        if (illegal_o !== c.ill) report_mismatch(name, "illegal_o", c.ill, illegal_o);
        if (c.valid && rd_o !== c.rd) report_mismatch(name, "rd_o", c.rd, rd_o);
        if (c.valid && !c.ill && result_o !== c.res) begin
            report_mismatch(name, "result_o", c.res, result_o);
        end
        if (c.valid && c.has_tgt && target_o !== c.tgt) begin
            report_mismatch(name, "target_o", c.tgt, target_o);
        end
    endtask

    task automatic run_test(input int test, input string name, input int n);
        int          errs_before;
        logic [31:0] w;
        logic [31:0] s;
        logic [31:0] pc;
        errs_before = errors;
        for (int i = 0; i < n + 2; i++) begin
            @(posedge i_clk);
            if (wb_en) mregs[wb_idx] = wb_data; // the register file writes a cycle after retire.
            wb_en = pend.valid & pend.wr;
            wb_idx = pend.rd;
            wb_data = pend.res;
            chk = pend;
            s = $random(seed);
            if (i < n && s[23:21] != 3'd0) begin
                gen_instr(test, i, w);
                pc = $random(seed);
                pc[1:0] = 2'b00;
                predict(w, pc, pend);
                valid_i <= 1'b1;
                instr_i <= w;
                pc_i <= pc;
            end else begin
                pend = '0;
                valid_i <= 1'b0;
                instr_i <= s;
            end
            @(negedge i_clk);
            compare_outputs(name, chk);
        end
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s passed", name);
        end else begin
            tests_bad++;
            $display("test %s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        i_clk = 1'b0;
        arst_n_i = 1'b0;
        valid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        pend = '0;
        wb_en = 1'b0;
        wb_idx = '0;
        wb_data = '0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        repeat (8) @(posedge i_clk);
        arst_n_i <= 1'b1;
        run_test(0, "reset_idle", 32);
        run_test(1, "alu_ops", 200);
        run_test(2, "upper_jump", 120);
        run_test(3, "branches", 120);
        run_test(4, "load_store", 120);
        run_test(5, "illegal_x0", 120);
        $display("tests passed %0d failed %0d errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
